// ==== logic/axi_mem_pkg.sv ====
package axi_mem_pkg;

    // axi burst types.
    localparam logic [1:0] burst_fixed = 2'b00;
    localparam logic [1:0] burst_incr  = 2'b01;
    localparam logic [1:0] burst_wrap  = 2'b10;

    localparam logic [1:0] resp_okay   = 2'b00;

    localparam int ID_W   = 12;
    localparam int ADDR_W = 32;
    localparam int DATA_W = 32;
    localparam int STRB_W = DATA_W / 8;
    localparam int LEN_W  = 8;

    localparam int MEM_WORDS = 1024; // 4 KiB, higher addresses alias.
    localparam int MEM_AW    = $clog2(MEM_WORDS);

    // busy for the last REFRESH_CYCLES of each period.
    localparam int REFRESH_PERIOD = 64;
    localparam int REFRESH_CYCLES = 3;
    localparam int REFRESH_W      = $clog2(REFRESH_PERIOD);

    // bridge states.
    localparam logic [1:0] st_idle  = 2'b00;
    localparam logic [1:0] st_write = 2'b01;
    localparam logic [1:0] st_resp  = 2'b10;
    localparam logic [1:0] st_read  = 2'b11;

endpackage

// ==== logic/burst_addr_gen.sv ====
`timescale 1ns/1ps

module burst_addr_gen (
    input  logic                           aclk,
    input  logic                           aresetn,
    input  logic                           load,
    input  logic                           step,
    input  logic [1:0]                     burst,
    input  logic [axi_mem_pkg::ADDR_W-1:0] start_addr,
    input  logic [axi_mem_pkg::LEN_W-1:0]  len,
    input  logic [2:0]                     size,
    output logic [axi_mem_pkg::ADDR_W-1:0] cur_addr
);
    import axi_mem_pkg::*;

    logic [ADDR_W-1:0] addr_q;
    logic [ADDR_W-1:0] mask_q; // set bits never change during the burst.
    logic [ADDR_W-1:0] mask_d;
    logic [2:0]        size_q;
    logic [ADDR_W-1:0] addr_inc;

    always_comb begin
        case (burst)
            burst_fixed: mask_d = '1;
            // wrap boundary is the total burst size in bytes.
            burst_wrap:  mask_d = ~(((ADDR_W'(len) + ADDR_W'(1)) << size) - ADDR_W'(1));
            default:     mask_d = '0;
        endcase
    end

    assign addr_inc = addr_q + (ADDR_W'(1) << size_q);

    always_ff @(posedge aclk or negedge aresetn) begin
        if (!aresetn) begin
            addr_q <= '0;
            mask_q <= '0;
            size_q <= '0;
        end else if (load) begin
            addr_q <= start_addr;
            mask_q <= mask_d;
            size_q <= size;
        end else if (step) begin
            addr_q <= (addr_q & mask_q) | (addr_inc & ~mask_q);
        end
    end

    assign cur_addr = addr_q;

    // only power-of-two wrap lengths are legal.
    wrap_len_legal: assert property (@(posedge aclk) disable iff (!aresetn)
        load && burst == burst_wrap |->
            len == LEN_W'(1) || len == LEN_W'(3) || len == LEN_W'(7) || len == LEN_W'(15));

endmodule

// ==== logic/axi2mem_bridge.sv ====
`timescale 1ns/1ps

module axi2mem_bridge (
    input  logic                           aclk,
    input  logic                           aresetn,
    input  logic [axi_mem_pkg::ID_W-1:0]   s_awid,
    input  logic [axi_mem_pkg::ADDR_W-1:0] s_awaddr,
    input  logic [axi_mem_pkg::LEN_W-1:0]  s_awlen,
    input  logic [2:0]                     s_awsize,
    input  logic [1:0]                     s_awburst,
    input  logic                           s_awvalid,
    output logic                           s_awready,
    input  logic [axi_mem_pkg::DATA_W-1:0] s_wdata,
    input  logic [axi_mem_pkg::STRB_W-1:0] s_wstrb,
    input  logic                           s_wlast,
    input  logic                           s_wvalid,
    output logic                           s_wready,
    output logic [axi_mem_pkg::ID_W-1:0]   s_bid,
    output logic [1:0]                     s_bresp,
    output logic                           s_bvalid,
    input  logic                           s_bready,
    input  logic [axi_mem_pkg::ID_W-1:0]   s_arid,
    input  logic [axi_mem_pkg::ADDR_W-1:0] s_araddr,
    input  logic [axi_mem_pkg::LEN_W-1:0]  s_arlen,
    input  logic [2:0]                     s_arsize,
    input  logic [1:0]                     s_arburst,
    input  logic                           s_arvalid,
    output logic                           s_arready,
    output logic [axi_mem_pkg::ID_W-1:0]   s_rid,
    output logic [axi_mem_pkg::DATA_W-1:0] s_rdata,
    output logic [1:0]                     s_rresp,
    output logic                           s_rlast,
    output logic                           s_rvalid,
    input  logic                           s_rready,
    output logic                           m_cs,
    output logic                           m_we,
    output logic [axi_mem_pkg::ADDR_W-1:0] m_addr,
    output logic [axi_mem_pkg::STRB_W-1:0] m_byte,
    output logic [axi_mem_pkg::DATA_W-1:0] m_di,
    input  logic [axi_mem_pkg::DATA_W-1:0] m_do,
    input  logic                           m_busy
);
    import axi_mem_pkg::*;

    logic [1:0]        state;
    logic [1:0]        state_nxt;
    logic [ID_W-1:0]   id_q;
    logic [LEN_W-1:0]  cnt;       // beats left minus one.
    logic              last_beat;
    logic              req_q;     // read word on m_do this cycle.
    logic              hold_q;    // word parked in skid_q.
    logic [DATA_W-1:0] skid_q;
    logic              ar_acc;
    logic              aw_acc;
    logic              w_acc;
    logic              r_acc;
    logic              rd_issue;
    logic              load;
    logic [1:0]        ld_burst;
    logic [ADDR_W-1:0] ld_addr;
    logic [LEN_W-1:0]  ld_len;
    logic [2:0]        ld_size;
    logic [ADDR_W-1:0] cur_addr;

    assign s_arready = (state == st_idle);
    assign s_awready = (state == st_idle) && !s_arvalid; // read wins a tie.
    assign s_wready  = (state == st_write) && !m_busy;
    assign s_bvalid  = (state == st_resp);
    assign s_rvalid  = req_q || hold_q;

    assign ar_acc    = s_arvalid && s_arready;
    assign aw_acc    = s_awvalid && s_awready;
    assign w_acc     = s_wvalid && s_wready;
    assign r_acc     = s_rvalid && s_rready;
    assign load      = ar_acc || aw_acc;
    assign last_beat = (cnt == '0);

    assign ld_burst = ar_acc ? s_arburst : s_awburst;
    assign ld_addr  = ar_acc ? s_araddr : s_awaddr;
    assign ld_len   = ar_acc ? s_arlen : s_awlen;
    assign ld_size  = ar_acc ? s_arsize : s_awsize;

    // next read only once the pending word leaves this cycle.
    assign rd_issue = (state == st_read) && !m_busy &&
                      (!s_rvalid || (s_rready && !last_beat));

    assign m_cs   = rd_issue || ((state == st_write) && s_wvalid && !m_busy);
    assign m_we   = (state == st_write);
    assign m_addr = cur_addr;
    assign m_byte = s_wstrb;
    assign m_di   = s_wdata;

    assign s_bid   = id_q;
    assign s_bresp = resp_okay;
    assign s_rid   = id_q;
    assign s_rresp = resp_okay;
    assign s_rdata = hold_q ? skid_q : m_do;
    assign s_rlast = s_rvalid && last_beat;

    burst_addr_gen u_addr (
        .aclk       (aclk),
        .aresetn    (aresetn),
        .load       (load),
        .step       (m_cs),
        .burst      (ld_burst),
        .start_addr (ld_addr),
        .len        (ld_len),
        .size       (ld_size),
        .cur_addr   (cur_addr)
    );

    always_comb begin
        state_nxt = state;
        case (state)
            st_idle: begin
                if (ar_acc) begin
                    state_nxt = st_read;
                end else if (aw_acc) begin
                    state_nxt = st_write;
                end
            end
            st_write: if (w_acc && last_beat) state_nxt = st_resp;
            st_resp:  if (s_bready) state_nxt = st_idle;
            st_read:  if (r_acc && last_beat) state_nxt = st_idle;
            default:  state_nxt = st_idle;
        endcase
    end

    always_ff @(posedge aclk or negedge aresetn) begin
        if (!aresetn) begin
            state <= st_idle;
        end else begin
            state <= state_nxt;
        end
    end

    always_ff @(posedge aclk or negedge aresetn) begin
        if (!aresetn) begin
            id_q <= '0;
            cnt  <= '0;
        end else if (load) begin
            id_q <= ar_acc ? s_arid : s_awid;
            cnt  <= ld_len;
        end else if (w_acc || r_acc) begin
            cnt <= cnt - LEN_W'(1);
        end
    end

    always_ff @(posedge aclk or negedge aresetn) begin
        if (!aresetn) begin
            req_q  <= 1'b0;
            hold_q <= 1'b0;
        end else begin
            req_q <= rd_issue;
            if (req_q && !s_rready) begin
                hold_q <= 1'b1;
            end else if (r_acc) begin
                hold_q <= 1'b0;
            end
        end
    end

    always_ff @(posedge aclk) begin
        if (req_q && !s_rready) skid_q <= m_do; // r stalled.
    end

    // a new read never lands beside a parked word.
    one_read_in_flight: assert property (@(posedge aclk) disable iff (!aresetn)
        m_cs && !m_we |=> !hold_q);

    rvalid_held: assert property (@(posedge aclk) disable iff (!aresetn)
        s_rvalid && !s_rready |=> s_rvalid && $stable(s_rdata) && $stable(s_rlast));

    // b never overlaps a read beat.
    bvalid_no_read: assert property (@(posedge aclk) disable iff (!aresetn)
        s_bvalid |-> !s_rvalid);

    wlast_matches_len: assert property (@(posedge aclk) disable iff (!aresetn)
        w_acc |-> s_wlast == last_beat);

endmodule

// ==== logic/sram_bank.sv ====
`timescale 1ns/1ps

module sram_bank (
    input  logic                           aclk,
    input  logic                           aresetn,
    input  logic                           cs,
    input  logic                           we,
    input  logic [axi_mem_pkg::ADDR_W-1:0] addr,
    input  logic [axi_mem_pkg::STRB_W-1:0] byte_en,
    input  logic [axi_mem_pkg::DATA_W-1:0] di,
    output logic [axi_mem_pkg::DATA_W-1:0] rdata,
    output logic                           busy
);
    import axi_mem_pkg::*;

    logic [DATA_W-1:0]    mem [MEM_WORDS];
    logic [MEM_AW-1:0]    idx;
    logic [REFRESH_W-1:0] ref_cnt;
    logic                 acc;

    assign idx  = addr[MEM_AW+1:2]; // word index.
    assign busy = (ref_cnt >= REFRESH_W'(REFRESH_PERIOD - REFRESH_CYCLES));
    assign acc  = cs && !busy;

    always_ff @(posedge aclk or negedge aresetn) begin
        if (!aresetn) begin
            ref_cnt <= '0;
        end else if (ref_cnt == REFRESH_W'(REFRESH_PERIOD - 1)) begin
            ref_cnt <= '0;
        end else begin
            ref_cnt <= ref_cnt + REFRESH_W'(1);
        end
    end

    always_ff @(posedge aclk) begin
        if (acc && we) begin
            for (int b = 0; b < STRB_W; b++) begin
                if (byte_en[b]) mem[idx][8*b +: 8] <= di[8*b +: 8];
            end
        end
        // rdata keeps its value until the next read.
        if (acc && !we) begin
            rdata <= mem[idx];
        end
    end

    cs_outside_refresh: assert property (@(posedge aclk) disable iff (!aresetn)
        cs |-> !busy);

endmodule

// ==== logic/axi_mem_subsys.sv ====
`timescale 1ns/1ps

module axi_mem_subsys (
    input  logic                           aclk,
    input  logic                           aresetn,
    input  logic [axi_mem_pkg::ID_W-1:0]   s_awid,
    input  logic [axi_mem_pkg::ADDR_W-1:0] s_awaddr,
    input  logic [axi_mem_pkg::LEN_W-1:0]  s_awlen,
    input  logic [2:0]                     s_awsize,
    input  logic [1:0]                     s_awburst,
    input  logic                           s_awvalid,
    output logic                           s_awready,
    input  logic [axi_mem_pkg::DATA_W-1:0] s_wdata,
    input  logic [axi_mem_pkg::STRB_W-1:0] s_wstrb,
    input  logic                           s_wlast,
    input  logic                           s_wvalid,
    output logic                           s_wready,
    output logic [axi_mem_pkg::ID_W-1:0]   s_bid,
    output logic [1:0]                     s_bresp,
    output logic                           s_bvalid,
    input  logic                           s_bready,
    input  logic [axi_mem_pkg::ID_W-1:0]   s_arid,
    input  logic [axi_mem_pkg::ADDR_W-1:0] s_araddr,
    input  logic [axi_mem_pkg::LEN_W-1:0]  s_arlen,
    input  logic [2:0]                     s_arsize,
    input  logic [1:0]                     s_arburst,
    input  logic                           s_arvalid,
    output logic                           s_arready,
    output logic [axi_mem_pkg::ID_W-1:0]   s_rid,
    output logic [axi_mem_pkg::DATA_W-1:0] s_rdata,
    output logic [1:0]                     s_rresp,
    output logic                           s_rlast,
    output logic                           s_rvalid,
    input  logic                           s_rready
);
    import axi_mem_pkg::*;

    // memory port between bridge and bank.
    logic              mem_cs;
    logic              mem_we;
    logic [ADDR_W-1:0] mem_addr;
    logic [STRB_W-1:0] mem_byte;
    logic [DATA_W-1:0] mem_di;
    logic [DATA_W-1:0] mem_do;
    logic              mem_busy;

    axi2mem_bridge u_bridge (
        .aclk      (aclk),
        .aresetn   (aresetn),
        .s_awid    (s_awid),
        .s_awaddr  (s_awaddr),
        .s_awlen   (s_awlen),
        .s_awsize  (s_awsize),
        .s_awburst (s_awburst),
        .s_awvalid (s_awvalid),
        .s_awready (s_awready),
        .s_wdata   (s_wdata),
        .s_wstrb   (s_wstrb),
        .s_wlast   (s_wlast),
        .s_wvalid  (s_wvalid),
        .s_wready  (s_wready),
        .s_bid     (s_bid),
        .s_bresp   (s_bresp),
        .s_bvalid  (s_bvalid),
        .s_bready  (s_bready),
        .s_arid    (s_arid),
        .s_araddr  (s_araddr),
        .s_arlen   (s_arlen),
        .s_arsize  (s_arsize),
        .s_arburst (s_arburst),
        .s_arvalid (s_arvalid),
        .s_arready (s_arready),
        .s_rid     (s_rid),
        .s_rdata   (s_rdata),
        .s_rresp   (s_rresp),
        .s_rlast   (s_rlast),
        .s_rvalid  (s_rvalid),
        .s_rready  (s_rready),
        .m_cs      (mem_cs),
        .m_we      (mem_we),
        .m_addr    (mem_addr),
        .m_byte    (mem_byte),
        .m_di      (mem_di),
        .m_do      (mem_do),
        .m_busy    (mem_busy)
    );

    sram_bank u_sram (
        .aclk    (aclk),
        .aresetn (aresetn),
        .cs      (mem_cs),
        .we      (mem_we),
        .addr    (mem_addr),
        .byte_en (mem_byte),
        .di      (mem_di),
        .rdata   (mem_do),
        .busy    (mem_busy)
    );

endmodule

// ==== bench/tb_axi_mem.sv ====
`timescale 1ns/1ps

module tb_axi_mem;
    import axi_mem_pkg::*;

    logic              aclk;
    logic              aresetn;
    logic [ID_W-1:0]   s_awid;
    logic [ADDR_W-1:0] s_awaddr;
    logic [LEN_W-1:0]  s_awlen;
    logic [2:0]        s_awsize;
    logic [1:0]        s_awburst;
    logic              s_awvalid;
    logic              s_awready;
    logic [DATA_W-1:0] s_wdata;
    logic [STRB_W-1:0] s_wstrb;
    logic              s_wlast;
    logic              s_wvalid;
    logic              s_wready;
    logic [ID_W-1:0]   s_bid;
    logic [1:0]        s_bresp;
    logic              s_bvalid;
    logic              s_bready;
    logic [ID_W-1:0]   s_arid;
    logic [ADDR_W-1:0] s_araddr;
    logic [LEN_W-1:0]  s_arlen;
    logic [2:0]        s_arsize;
    logic [1:0]        s_arburst;
    logic              s_arvalid;
    logic              s_arready;
    logic [ID_W-1:0]   s_rid;
    logic [DATA_W-1:0] s_rdata;
    logic [1:0]        s_rresp;
    logic              s_rlast;
    logic              s_rvalid;
    logic              s_rready;

    logic [DATA_W-1:0] ref_mem [MEM_WORDS]; // expected memory contents.
    logic [DATA_W-1:0] exp_rdata [$];
    logic              exp_rlast [$];
    logic [ID_W-1:0]   exp_rid [$];
    logic [ID_W-1:0]   exp_bid [$];
    logic [31:0]       lcg_state;
    int                max_wait = 1000;

    axi_mem_subsys u_dut (.*);

    initial aclk = 1'b0;
    always #4 aclk = ~aclk;

    function automatic logic [31:0] lcg_next();
        lcg_state = lcg_state * 32'd1664525 + 32'd1013904223;
        return lcg_state;
    endfunction

    function automatic int pick(int n);
        return int'((lcg_next() >> 8) % 32'(n));
    endfunction

    function automatic logic coin();
        return lcg_next() < 32'hc000_0000; // ready about three cycles in four.
    endfunction

    function automatic logic [ADDR_W-1:0] beat_addr(logic [1:0] burst, logic [ADDR_W-1:0] start,
                                                    logic [2:0] size, logic [LEN_W-1:0] len,
                                                    int beat);
        logic [ADDR_W-1:0] bytes;
        logic [ADDR_W-1:0] span;
        bytes = ADDR_W'(1) << size;
        span  = bytes * (ADDR_W'(len) + ADDR_W'(1));
        if (burst == burst_fixed) begin
            return start;
        end else if (burst == burst_wrap) begin
            // stays inside the span-aligned block around start.
            return start - (start % span) + ((start + bytes * ADDR_W'(beat)) % span);
        end
        return start + bytes * ADDR_W'(beat);
    endfunction

    function automatic logic [STRB_W-1:0] lane_mask(logic [ADDR_W-1:0] addr, logic [2:0] size);
        if (size == 3'd0) return STRB_W'(1) << addr[1:0];
        if (size == 3'd1) return STRB_W'(3) << {addr[1], 1'b0};
        return '1;
    endfunction

    function automatic logic [DATA_W-1:0] merge_bytes(logic [DATA_W-1:0] old_word,
                                                      logic [DATA_W-1:0] new_word,
                                                      logic [STRB_W-1:0] strb);
        logic [DATA_W-1:0] word;
        word = old_word;
        for (int b = 0; b < STRB_W; b++) begin
            if (strb[b]) word[8*b +: 8] = new_word[8*b +: 8];
        end
        return word;
    endfunction

    task automatic fail_run(string line);
        $display("%s", line);
        $display("sim failed");
        $fatal(1, "stopped at the first error");
    endtask

    task automatic check_rdata(logic [DATA_W-1:0] got, logic [DATA_W-1:0] exp);
        if (got !== exp) begin
            fail_run($sformatf("error at %0t: rdata %h, expected %h", $time, got, exp));
        end
    endtask

    task automatic check_resp(logic [1:0] resp, logic [ID_W-1:0] id, logic [ID_W-1:0] exp_id);
        if (resp !== resp_okay || id !== exp_id) begin
            fail_run($sformatf("error at %0t: resp %0d id %h, expected okay id %h",
                               $time, resp, id, exp_id));
        end
    endtask

    task automatic check_last(logic got, logic exp);
        if (got !== exp) begin
            fail_run($sformatf("error at %0t: rlast %b, expected %b", $time, got, exp));
        end
    endtask

    // handshakes sampled mid-cycle, where every port is settled.
    always @(negedge aclk) begin
        if (s_rvalid && s_rready) begin
            if (exp_rdata.size() == 0) begin
                fail_run("an R beat arrived while no read was outstanding");
            end else begin
                check_rdata(s_rdata, exp_rdata.pop_front());
                check_last(s_rlast, exp_rlast.pop_front());
                check_resp(s_rresp, s_rid, exp_rid.pop_front());
            end
        end
        if (s_bvalid && s_bready) begin
            if (exp_bid.size() == 0) begin
                fail_run("a B response arrived while no write was outstanding");
            end else if (exp_rdata.size() != 0) begin
                fail_run("a B response arrived before the pending read had finished");
            end else begin
                check_resp(s_bresp, s_bid, exp_bid.pop_front());
            end
        end
    end

    task automatic wait_for(string ch);
        int   n;
        logic ready;
        n = 0;
        ready = 1'b0;
        while (!ready) begin
            @(negedge aclk);
            ready = (ch == "AW") ? s_awready : (ch == "W") ? s_wready : s_arready;
            n++;
            if (!ready && n > max_wait) begin
                fail_run($sformatf("timeout at %0t: %s channel never became ready", $time, ch));
            end
        end
        @(posedge aclk);
        #1;
    endtask

    // takes beats on R or B with random ready gaps.
    task automatic drain(string ch, int beats);
        int   got;
        int   n;
        logic ready;
        got = 0;
        n = 0;
        while (got < beats) begin
            ready = coin();
            if (ch == "R") begin
                s_rready = ready;
            end else begin
                s_bready = ready;
            end
            @(negedge aclk);
            if (ready && ((ch == "R") ? s_rvalid : s_bvalid)) begin
                got++;
                n = 0;
            end else begin
                n++;
            end
            if (n > max_wait) begin
                fail_run($sformatf("timeout at %0t: %s channel stopped delivering", $time, ch));
            end
            @(posedge aclk);
            #1;
        end
        if (ch == "R") begin
            s_rready = 1'b0;
        end else begin
            s_bready = 1'b0;
        end
    endtask

    task automatic axi_write(logic [ID_W-1:0] id, logic [1:0] burst, logic [ADDR_W-1:0] addr,
                             logic [2:0] size, logic [LEN_W-1:0] len, logic partial);
        logic [ADDR_W-1:0] a;
        logic [STRB_W-1:0] strb;
        exp_bid.push_back(id);
        s_awid    = id;
        s_awaddr  = addr;
        s_awlen   = len;
        s_awsize  = size;
        s_awburst = burst;
        s_awvalid = 1'b1;
        wait_for("AW");
        s_awvalid = 1'b0;
        for (int i = 0; i <= int'(len); i++) begin
            a    = beat_addr(burst, addr, size, len, i);
            strb = lane_mask(a, size);
            if (partial) strb = strb & STRB_W'(lcg_next() >> 24);
            s_wdata  = lcg_next();
            s_wstrb  = strb;
            s_wlast  = (i == int'(len));
            s_wvalid = 1'b1;
            wait_for("W");
            ref_mem[a[MEM_AW+1:2]] = merge_bytes(ref_mem[a[MEM_AW+1:2]], s_wdata, strb);
        end
        s_wvalid = 1'b0;
        s_wlast  = 1'b0;
        drain("B", 1);
    endtask

    task automatic axi_read(logic [ID_W-1:0] id, logic [1:0] burst, logic [ADDR_W-1:0] addr,
                            logic [2:0] size, logic [LEN_W-1:0] len);
        logic [ADDR_W-1:0] a;
        for (int i = 0; i <= int'(len); i++) begin
            a = beat_addr(burst, addr, size, len, i);
            exp_rdata.push_back(ref_mem[a[MEM_AW+1:2]]);
            exp_rlast.push_back(i == int'(len));
            exp_rid.push_back(id);
        end
        s_arid    = id;
        s_araddr  = addr;
        s_arlen   = len;
        s_arsize  = size;
        s_arburst = burst;
        s_arvalid = 1'b1;
        wait_for("AR");
        s_arvalid = 1'b0;
        drain("R", int'(len) + 1);
    endtask

    task automatic write_read(logic [1:0] burst, logic [ADDR_W-1:0] addr, logic [2:0] size,
                              logic [LEN_W-1:0] len, logic partial);
        axi_write(ID_W'(lcg_next()), burst, addr, size, len, partial);
        axi_read(ID_W'(lcg_next()), burst, addr, size, len);
    endtask

    initial begin
        logic [ADDR_W-1:0] addr;
        logic [LEN_W-1:0]  len;
        int                span;
        lcg_state = 32'hff312bf7;
        aresetn   = 1'b0;
        s_awid    = '0;
        s_awaddr  = '0;
        s_awlen   = '0;
        s_awsize  = '0;
        s_awburst = '0;
        s_awvalid = 1'b0;
        s_wdata   = '0;
        s_wstrb   = '0;
        s_wlast   = 1'b0;
        s_wvalid  = 1'b0;
        s_bready  = 1'b0;
        s_arid    = '0;
        s_araddr  = '0;
        s_arlen   = '0;
        s_arsize  = '0;
        s_arburst = '0;
        s_arvalid = 1'b0;
        s_rready  = 1'b0;
        repeat (3) @(posedge aclk);
        #1;
        aresetn = 1'b1;

        // fill the first 1 KiB, the window all later bursts use.
        write_read(burst_incr, '0, 3'd2, 8'd255, 1'b0);
        repeat (6) begin
            len  = LEN_W'(pick(32));
            addr = ADDR_W'(pick(256 - int'(len))) << 2;
            write_read(burst_incr, addr, 3'd2, len, 1'b0);
        end
        for (int w = 4; w <= 16; w = w * 2) begin
            span = 4 * w;
            addr = ADDR_W'(pick(1024 / span) * span + 4 * (1 + pick(w - 1))); // mid-block.
            write_read(burst_wrap, addr, 3'd2, LEN_W'(w - 1), 1'b1);
            axi_read(ID_W'(lcg_next()), burst_incr, addr & ~ADDR_W'(span - 1), 3'd2,
                     LEN_W'(w - 1));
        end
        addr = ADDR_W'(pick(256)) << 2;
        write_read(burst_fixed, addr, 3'd2, LEN_W'(3 + pick(6)), 1'b1);
        axi_read(ID_W'(lcg_next()), burst_incr, addr, 3'd2, '0);
        for (int sz = 0; sz < 2; sz++) begin
            addr = ADDR_W'(pick(768)) & ~((ADDR_W'(1) << sz) - ADDR_W'(1));
            write_read(burst_incr, addr, 3'(sz), LEN_W'(7 + pick(9)), 1'b1);
        end
        repeat (8) begin
            len  = LEN_W'(pick(64));
            addr = ADDR_W'(pick(256 - int'(len))) << 2;
            write_read(burst_incr, addr, 3'd2, len, 1'b1);
        end
        // ar and aw in the same cycle, the read must see the old words.
        addr = ADDR_W'(pick(240)) << 2;
        fork
            axi_read(ID_W'(lcg_next()), burst_incr, addr, 3'd2, 8'd7);
            axi_write(ID_W'(lcg_next()), burst_incr, addr, 3'd2, 8'd7, 1'b0);
        join
        axi_read(ID_W'(lcg_next()), burst_incr, addr, 3'd2, 8'd7);

        // an extra beat would still be pending here.
        if (s_rvalid || s_bvalid || !s_arready) begin
            fail_run("the DUT did not return to idle after the last transaction");
        end else begin
            $display("sim passed");
            $finish;
        end
    end

endmodule

// ==== filelist.f ====
logic/axi_mem_pkg.sv
logic/burst_addr_gen.sv
logic/axi2mem_bridge.sv
logic/sram_bank.sv
logic/axi_mem_subsys.sv
bench/tb_axi_mem.sv

// ==== run_sim.sh ====
#!/bin/sh
cd "$(dirname "$0")" || exit 1
rm -rf obj_dir sim.log
verilator --binary --timing --assert -Wno-fatal -f filelist.f --top-module tb_axi_mem \
    -o tb_axi_mem && ./obj_dir/tb_axi_mem > sim.log 2>&1
grep -q "sim passed" sim.log 2>/dev/null && echo "PASS" || { echo "FAIL"; exit 1; }
